/* frameBufPkg.sv */
package frameBufPkg;

	localparam int ADDR_W = 22;		// Memory word address
	localparam int DATA_W = 16;		// Pixel word
	localparam int LEN_W = 9;		// Burst length, up to 256
	localparam int FIFO_DEPTH = 512;	// Words per port FIFO
	localparam int LEVEL_W = 10;		// Holds 0 to FIFO_DEPTH
	localparam int PTR_W = $clog2(FIFO_DEPTH);

	localparam int WR_PORTS = 2;
	localparam int RD_PORTS = 2;
	localparam int PORT_W = 1;		// Port index

	typedef logic [ADDR_W-1:0] addrT;
	typedef logic [DATA_W-1:0] dataT;
	typedef logic [LEN_W-1:0] lenT;
	typedef logic [LEVEL_W-1:0] levelT;

	// Frame geometry and bank offsets
	localparam int FRAME_W = 640;
	localparam int FRAME_H = 480;
	localparam addrT FRAME_WORDS = ADDR_W'(FRAME_W * FRAME_H);
	localparam addrT BANK0 = 22'h000000;
	localparam addrT BANK1 = 22'h100000;

	// Reset windows per port, reads ping-pong against writes
	localparam addrT WR_DEF_START [WR_PORTS] = '{BANK0, BANK1};
	localparam addrT WR_DEF_MAX [WR_PORTS] = '{BANK0 + FRAME_WORDS, BANK1 + FRAME_WORDS};
	localparam addrT RD_DEF_START [RD_PORTS] = '{BANK1, BANK0};
	localparam addrT RD_DEF_MAX [RD_PORTS] = '{BANK1 + FRAME_WORDS, BANK0 + FRAME_WORDS};

endpackage

/* portFifo.sv */
`timescale 1ns/1ps

module portFifo import frameBufPkg::*; (
	input logic CLK,
	input logic RESET_N,
	input logic clear,		// Synchronous flush
	input logic push,
	input dataT pushData,
	input logic pop,
	output dataT popData,		// Head word, show-ahead
	output logic full,
	output logic empty,
	output levelT level
);

	dataT mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wPtr;
	logic [PTR_W-1:0] rPtr;
	logic doPush;
	logic doPop;

	assign full = (level == LEVEL_W'(FIFO_DEPTH));
	assign empty = (level == '0);
	assign doPush = push && !full;		// Overflow push dropped
	assign doPop = pop && !empty;		// Underflow pop dropped
	assign popData = mem[rPtr];

	always_ff @(posedge CLK)
	begin
		if (doPush)
		begin
			mem[wPtr] <= pushData;
		end
	end

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			wPtr <= '0;
			rPtr <= '0;
			level <= '0;
		end
		else if (clear)
		begin
			wPtr <= '0;
			rPtr <= '0;
			level <= '0;
		end
		else
		begin
			if (doPush)
				wPtr <= wPtr + 1'b1;	// Wraps at depth
			if (doPop)
				rPtr <= rPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	// Pointer distance always matches the stored word count
	assert property (@(posedge CLK) disable iff (!RESET_N)
		wPtr - rPtr == level[PTR_W-1:0]);
	// Count never runs past the buffer
	assert property (@(posedge CLK) disable iff (!RESET_N)
		level <= LEVEL_W'(FIFO_DEPTH));

endmodule

/* writePort.sv */
`timescale 1ns/1ps

module writePort import frameBufPkg::*; #(
	parameter addrT defStart = '0,
	parameter addrT defMax = '0
) (
	input logic CLK,
	input logic RESET_N,
	input dataT wrData,
	input logic wrPush,
	input logic wrLoad,		// Register load and FIFO clear
	input addrT wrStart,
	input addrT wrMax,
	input lenT wrLength,
	output logic wrFull,
	output levelT wrLevel,
	input logic grant,
	input logic fifoPop,
	input logic burstDone,
	output dataT popData,
	output logic burstReq,
	output addrT burstAddr,
	output lenT burstLen
);

	addrT startReg;
	addrT maxReg;

	portFifo i_portFifo (
		.CLK(CLK),
		.RESET_N(RESET_N),
		.clear(wrLoad),
		.push(wrPush),
		.pushData(wrData),
		.pop(fifoPop && grant),		// Only the granted port drains
		.popData(popData),
		.full(wrFull),
		.empty(),
		.level(wrLevel)
	);

	// Enough words buffered for one whole burst
	assign burstReq = !wrLoad && (burstLen != '0) && (wrLevel >= {1'b0, burstLen});

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			startReg <= defStart;
			maxReg <= defMax;
			burstAddr <= defStart;
			burstLen <= '0;		// Idle until loaded
		end
		else if (wrLoad)
		begin
			startReg <= wrStart;
			maxReg <= wrMax;
			burstAddr <= wrStart;
			burstLen <= wrLength;
		end
		else if (burstDone && grant)
		begin
			if (burstAddr < maxReg - burstLen)
				burstAddr <= burstAddr + burstLen;
			else
				burstAddr <= startReg;	// Wrap to window start
		end
	end

endmodule

/* readPort.sv */
`timescale 1ns/1ps

module readPort import frameBufPkg::*; #(
	parameter addrT defStart = '0,
	parameter addrT defMax = '0
) (
	input logic CLK,
	input logic RESET_N,
	input logic rdPop,
	input logic rdLoad,		// Register load and FIFO clear
	input addrT rdStart,
	input addrT rdMax,
	input lenT rdLength,
	output dataT rdData,
	output logic rdEmpty,
	output levelT rdLevel,
	input logic grant,
	input logic rdPush,
	input dataT rdPushData,
	input logic burstDone,
	output logic burstReq,
	output addrT burstAddr,
	output lenT burstLen
);

	addrT startReg;
	addrT maxReg;

	portFifo i_portFifo (
		.CLK(CLK),
		.RESET_N(RESET_N),
		.clear(rdLoad),
		.push(rdPush && grant),		// Memory words land only here when granted
		.pushData(rdPushData),
		.pop(rdPop),
		.popData(rdData),
		.full(),
		.empty(rdEmpty),
		.level(rdLevel)
	);

	// Below one burst of data, room for a full burst is guaranteed
	assign burstReq = !rdLoad && (burstLen != '0) && (rdLevel < {1'b0, burstLen});

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			startReg <= defStart;
			maxReg <= defMax;
			burstAddr <= defStart;
			burstLen <= '0;
		end
		else if (rdLoad)
		begin
			startReg <= rdStart;
			maxReg <= rdMax;
			burstAddr <= rdStart;
			burstLen <= rdLength;
		end
		else if (burstDone && grant)
		begin
			if (burstAddr < maxReg - burstLen)
				burstAddr <= burstAddr + burstLen;
			else
				burstAddr <= startReg;
		end
	end

endmodule

/* burstArbiter.sv */
`timescale 1ns/1ps

module burstArbiter import frameBufPkg::*; (
	input logic CLK,
	input logic RESET_N,
	input logic [WR_PORTS-1:0] wrReq,
	input logic [RD_PORTS-1:0] rdReq,
	input addrT wrAddr [WR_PORTS],
	input addrT rdAddr [RD_PORTS],
	input lenT wrLen [WR_PORTS],
	input lenT rdLen [RD_PORTS],
	input logic burstDone,
	output logic [WR_PORTS-1:0] wrGrant,
	output logic [RD_PORTS-1:0] rdGrant,
	output logic [PORT_W-1:0] grantIdx,
	output logic grantIsWrite,
	output logic burstStart,		// One cycle per new grant
	output addrT burstAddr,
	output lenT burstLen
);

	logic busy;
	logic pickValid;
	logic pickWrite;
	logic [PORT_W-1:0] pickIdx;

	assign busy = |{wrGrant, rdGrant};

	// Reads before writes, low index first; last match wins
	always_comb
	begin
		pickValid = 1'b0;
		pickWrite = 1'b0;
		pickIdx = '0;
		for (int i = WR_PORTS - 1; i >= 0; i--)
		begin
			if (wrReq[i])
			begin
				pickValid = 1'b1;
				pickWrite = 1'b1;
				pickIdx = PORT_W'(i);
			end
		end
		for (int i = RD_PORTS - 1; i >= 0; i--)
		begin
			if (rdReq[i])
			begin
				pickValid = 1'b1;
				pickWrite = 1'b0;
				pickIdx = PORT_W'(i);
			end
		end
	end

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			wrGrant <= '0;
			rdGrant <= '0;
			grantIdx <= '0;
			grantIsWrite <= 1'b0;
			burstStart <= 1'b0;
		end
		else
		begin
			burstStart <= 1'b0;
			if (busy)
			begin
				if (burstDone)
				begin
					wrGrant <= '0;	// Release, port steps on this edge
					rdGrant <= '0;
				end
			end
			else if (pickValid)
			begin
				wrGrant <= pickWrite ? (WR_PORTS'(1) << pickIdx) : '0;
				rdGrant <= pickWrite ? '0 : (RD_PORTS'(1) << pickIdx);
				grantIdx <= pickIdx;
				grantIsWrite <= pickWrite;
				burstStart <= 1'b1;
			end
		end
	end

	// Snapshot of the winner's window
	always_ff @(posedge CLK)
	begin
		if (!busy && pickValid)
		begin
			burstAddr <= pickWrite ? wrAddr[pickIdx] : rdAddr[pickIdx];
			burstLen <= pickWrite ? wrLen[pickIdx] : rdLen[pickIdx];
		end
	end

	assert property (@(posedge CLK) disable iff (!RESET_N) $onehot0({wrGrant, rdGrant}));

endmodule

/* burstSequencer.sv */
`timescale 1ns/1ps

module burstSequencer import frameBufPkg::*; (
	input logic CLK,
	input logic RESET_N,
	input logic burstStart,
	input logic grantIsWrite,
	input logic [PORT_W-1:0] grantIdx,
	input addrT burstAddr,
	input lenT burstLen,
	input dataT wrPopData [WR_PORTS],
	output logic fifoPop,
	output logic rdPush,
	output dataT rdPushData,
	output logic burstDone,
	output logic memReq,		// Held until memAck
	output logic memWe,
	output addrT memAddr,
	output lenT memLen,
	input logic memAck,
	output logic memWrStrobe,
	output dataT memWrData,
	input logic memRdValid,
	input dataT memRdData
);

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		XFER,
		DONE
	} seqStateT;

	seqStateT state;
	lenT wordCnt;			// Words moved so far
	logic wordStep;
	logic lastWord;

	assign memReq = (state == REQ);
	assign memWe = grantIsWrite;
	assign memAddr = burstAddr;
	assign memLen = burstLen;

	// Write data comes straight off the granted FIFO head
	assign memWrStrobe = (state == XFER) && grantIsWrite;
	assign memWrData = wrPopData[grantIdx];
	assign fifoPop = memWrStrobe;

	assign rdPush = (state == XFER) && !grantIsWrite && memRdValid;
	assign rdPushData = memRdData;

	assign wordStep = memWrStrobe || rdPush;
	assign lastWord = wordStep && (wordCnt == burstLen - 1'b1);
	assign burstDone = (state == DONE);

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			state <= IDLE;
			wordCnt <= '0;
		end
		else
		begin
			case (state)
				IDLE:
					if (burstStart)
						state <= REQ;
				REQ:
					if (memAck)
					begin
						state <= XFER;
						wordCnt <= '0;
					end
				XFER:
					if (lastWord)
						state <= DONE;
					else if (wordStep)
						wordCnt <= wordCnt + 1'b1;
				default:
					state <= IDLE;	// DONE lasts one cycle
			endcase
		end
	end

	// Strobes must belong to a write grant held by the arbiter
	assert property (@(posedge CLK) disable iff (!RESET_N)
		memWrStrobe |-> $stable(grantIsWrite) && $stable(grantIdx));
	// Memory may only return data inside a read burst
	assert property (@(posedge CLK) disable iff (!RESET_N)
		memRdValid |-> (state == XFER) && !grantIsWrite);

endmodule

/* frameBufCtrl.sv */
`timescale 1ns/1ps

module frameBufCtrl import frameBufPkg::*; (
	input logic CLK,
	input logic RESET_N,
	// Write side
	input dataT wrData [WR_PORTS],
	input logic [WR_PORTS-1:0] wrPush,
	input logic [WR_PORTS-1:0] wrLoad,
	input addrT wrStart [WR_PORTS],
	input addrT wrMax [WR_PORTS],
	input lenT wrLength [WR_PORTS],
	output logic [WR_PORTS-1:0] wrFull,
	output levelT wrLevel [WR_PORTS],
	// Read side
	input logic [RD_PORTS-1:0] rdPop,
	input logic [RD_PORTS-1:0] rdLoad,
	input addrT rdStart [RD_PORTS],
	input addrT rdMax [RD_PORTS],
	input lenT rdLength [RD_PORTS],
	output dataT rdData [RD_PORTS],
	output logic [RD_PORTS-1:0] rdEmpty,
	output levelT rdLevel [RD_PORTS],
	// Burst memory port
	output logic memReq,
	output logic memWe,
	output addrT memAddr,
	output lenT memLen,
	input logic memAck,
	output logic memWrStrobe,
	output dataT memWrData,
	input logic memRdValid,
	input dataT memRdData
);

	logic [WR_PORTS-1:0] wrBurstReq;
	logic [RD_PORTS-1:0] rdBurstReq;
	addrT wrBurstAddr [WR_PORTS];
	addrT rdBurstAddr [RD_PORTS];
	lenT wrBurstLen [WR_PORTS];
	lenT rdBurstLen [RD_PORTS];
	dataT wrPopData [WR_PORTS];
	logic [WR_PORTS-1:0] wrGrant;
	logic [RD_PORTS-1:0] rdGrant;
	logic [PORT_W-1:0] grantIdx;
	logic grantIsWrite;
	logic burstStart;
	logic burstDone;
	addrT burstAddr;
	lenT burstLen;
	logic fifoPop;
	logic rdPush;
	dataT rdPushData;

	for (genvar i = 0; i < WR_PORTS; i++)
	begin : genWr
		writePort #(
			.defStart(WR_DEF_START[i]),
			.defMax(WR_DEF_MAX[i])
		) i_writePort (
			.CLK(CLK), .RESET_N(RESET_N),
			.wrData(wrData[i]), .wrPush(wrPush[i]), .wrLoad(wrLoad[i]),
			.wrStart(wrStart[i]), .wrMax(wrMax[i]), .wrLength(wrLength[i]),
			.wrFull(wrFull[i]), .wrLevel(wrLevel[i]),
			.grant(wrGrant[i]), .fifoPop(fifoPop), .burstDone(burstDone),
			.popData(wrPopData[i]), .burstReq(wrBurstReq[i]),
			.burstAddr(wrBurstAddr[i]), .burstLen(wrBurstLen[i])
		);
	end

	for (genvar i = 0; i < RD_PORTS; i++)
	begin : genRd
		readPort #(
			.defStart(RD_DEF_START[i]),
			.defMax(RD_DEF_MAX[i])
		) i_readPort (
			.CLK(CLK), .RESET_N(RESET_N),
			.rdPop(rdPop[i]), .rdLoad(rdLoad[i]),
			.rdStart(rdStart[i]), .rdMax(rdMax[i]), .rdLength(rdLength[i]),
			.rdData(rdData[i]), .rdEmpty(rdEmpty[i]), .rdLevel(rdLevel[i]),
			.grant(rdGrant[i]), .rdPush(rdPush), .rdPushData(rdPushData),
			.burstDone(burstDone), .burstReq(rdBurstReq[i]),
			.burstAddr(rdBurstAddr[i]), .burstLen(rdBurstLen[i])
		);
	end

	burstArbiter i_burstArbiter (
		.CLK(CLK), .RESET_N(RESET_N),
		.wrReq(wrBurstReq), .rdReq(rdBurstReq),
		.wrAddr(wrBurstAddr), .rdAddr(rdBurstAddr),
		.wrLen(wrBurstLen), .rdLen(rdBurstLen),
		.burstDone(burstDone),
		.wrGrant(wrGrant), .rdGrant(rdGrant),
		.grantIdx(grantIdx), .grantIsWrite(grantIsWrite), .burstStart(burstStart),
		.burstAddr(burstAddr), .burstLen(burstLen)
	);

	burstSequencer i_burstSequencer (
		.CLK(CLK), .RESET_N(RESET_N),
		.burstStart(burstStart), .grantIsWrite(grantIsWrite), .grantIdx(grantIdx),
		.burstAddr(burstAddr), .burstLen(burstLen), .wrPopData(wrPopData),
		.fifoPop(fifoPop), .rdPush(rdPush), .rdPushData(rdPushData),
		.burstDone(burstDone),
		.memReq(memReq), .memWe(memWe), .memAddr(memAddr), .memLen(memLen),
		.memAck(memAck), .memWrStrobe(memWrStrobe), .memWrData(memWrData),
		.memRdValid(memRdValid), .memRdData(memRdData)
	);

endmodule

/* frameBufCtrlTb.sv */
`timescale 1ns/1ps

module frameBufCtrlTb import frameBufPkg::*; ();

	localparam time CLK_PERIOD = 100;
	localparam time DRIVE_DELAY = 10;	// Inputs change after the rising edge
	localparam int SEED = 32'h8d89;
	localparam int TEST_CYCLES = 5 + 40 + 50 + 80 + 60 + 530;	// Rough cycles per test
	localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;

	logic CLK;
	logic RESET_N;
	dataT wrData [WR_PORTS];
	logic [WR_PORTS-1:0] wrPush;
	logic [WR_PORTS-1:0] wrLoad;
	addrT wrStart [WR_PORTS];
	addrT wrMax [WR_PORTS];
	lenT wrLength [WR_PORTS];
	logic [WR_PORTS-1:0] wrFull;
	levelT wrLevel [WR_PORTS];
	logic [RD_PORTS-1:0] rdPop;
	logic [RD_PORTS-1:0] rdLoad;
	addrT rdStart [RD_PORTS];
	addrT rdMax [RD_PORTS];
	lenT rdLength [RD_PORTS];
	dataT rdData [RD_PORTS];
	logic [RD_PORTS-1:0] rdEmpty;
	levelT rdLevel [RD_PORTS];
	logic memReq;
	logic memWe;
	addrT memAddr;
	lenT memLen;
	logic memAck;
	logic memWrStrobe;
	dataT memWrData;
	logic memRdValid;
	dataT memRdData;

	dataT memory [addrT];			// Sparse memory model
	addrT reqAddrQ [$];			// Log of accepted requests
	logic reqWeQ [$];
	lenT reqLenQ [$];
	logic ackHold = 1'b0;			// Stalls the memory ack while set
	int burstsDone = 0;
	int strobeCount = 0;
	int errors = 0;
	int testsRun = 0;

	frameBufCtrl i_frameBufCtrl (.*);

	initial
		CLK = 1'b0;
	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// Unwritten words read back as a pattern of the whole address
	function automatic dataT memWord(input addrT a);
		if (memory.exists(a))
			return memory[a];
		return dataT'(a) ^ dataT'(a >> 16) ^ 16'h5a3c;
	endfunction

	initial
	begin : memModel
		addrT addr;
		lenT len;
		logic we;
		int cnt;
		void'($urandom(SEED));
		forever
		begin
			@(negedge CLK);
			if (memReq)
			begin
				addr = memAddr;
				len = memLen;
				we = memWe;
				reqAddrQ.push_back(addr);
				reqWeQ.push_back(we);
				reqLenQ.push_back(len);
				while (ackHold)
					@(posedge CLK);
				repeat ($urandom_range(3, 0)) @(posedge CLK);	// Ack after 1 to 4 cycles
				@(posedge CLK);
				#DRIVE_DELAY memAck = 1'b1;
				@(posedge CLK);
				#DRIVE_DELAY memAck = 1'b0;
				cnt = 0;
				if (we)
				begin
					while (cnt < len)
					begin
						@(negedge CLK);
						if (memWrStrobe)
						begin
							memory[addrT'(addr + cnt)] = memWrData;
							cnt++;
						end
					end
				end
				else
				begin
					while (cnt < len)
					begin
						if ($urandom_range(2, 0) == 0)
							memRdValid = 1'b0;	// Gap
						else
						begin
							memRdValid = 1'b1;
							memRdData = memWord(addrT'(addr + cnt));
							cnt++;
						end
						@(posedge CLK);
						#DRIVE_DELAY;
					end
					memRdValid = 1'b0;
				end
				burstsDone++;
			end
		end
	end

	always @(negedge CLK)
	begin
		if (memWrStrobe)
			strobeCount++;
	end

	task automatic clearLog();
		reqAddrQ.delete();
		reqWeQ.delete();
		reqLenQ.delete();
	endtask

	task automatic loadWrite(input int idx, input addrT start, input addrT max, input lenT len);
		wrLoad[idx] = 1'b1;
		wrStart[idx] = start;
		wrMax[idx] = max;
		wrLength[idx] = len;
		@(posedge CLK);
		#DRIVE_DELAY;
		wrLoad[idx] = 1'b0;
	endtask

	task automatic loadRead(input int idx, input addrT start, input addrT max, input lenT len);
		rdLoad[idx] = 1'b1;
		rdStart[idx] = start;
		rdMax[idx] = max;
		rdLength[idx] = len;
		@(posedge CLK);
		#DRIVE_DELAY;
		rdLoad[idx] = 1'b0;
	endtask

	task automatic pushWords(input int idx, input int n, input dataT base);
		for (int i = 0; i < n; i++)
		begin
			wrData[idx] = dataT'(base + i);
			wrPush[idx] = 1'b1;
			@(posedge CLK);
			#DRIVE_DELAY;
		end
		wrPush[idx] = 1'b0;
	endtask

	task automatic waitBurstCount(input int target);
		while (burstsDone < target)
			@(posedge CLK);
		#DRIVE_DELAY;
	endtask

	task automatic testReset();
		testsRun++;
		@(negedge CLK);
		if (memReq !== 1'b0 || memWrStrobe !== 1'b0)
		begin
			$display("CHECK FAILED memReq/memWrStrobe got %h/%h expected 0/0", memReq, memWrStrobe);
			errors++;
		end
		if (wrFull !== '0 || rdEmpty !== '1)
		begin
			$display("CHECK FAILED wrFull/rdEmpty got %h/%h expected 0/3", wrFull, rdEmpty);
			errors++;
		end
		for (int i = 0; i < WR_PORTS; i++)
		begin
			if (wrLevel[i] !== '0 || rdLevel[i] !== '0)
			begin
				$display("CHECK FAILED wrLevel/rdLevel[%0d] got %h/%h expected 0", i, wrLevel[i],
					rdLevel[i]);
				errors++;
			end
		end
		@(posedge CLK);
		#DRIVE_DELAY;
	endtask

	task automatic testWriteBurst();
		int base;
		int strobeStart;
		testsRun++;
		clearLog();
		base = burstsDone;
		strobeStart = strobeCount;
		loadWrite(0, 22'h000100, 22'h000200, 8);
		pushWords(0, 8, 16'ha000);
		waitBurstCount(base + 1);
		if (reqAddrQ.size() != 1)
		begin
			$display("Expected one memory request for the write burst, saw %0d", reqAddrQ.size());
			errors++;
		end
		else if (reqAddrQ[0] !== 22'h000100 || reqWeQ[0] !== 1'b1 || reqLenQ[0] !== 9'd8)
		begin
			$display("CHECK FAILED memAddr/memWe/memLen got %h/%h/%h expected 000100/1/008",
				reqAddrQ[0], reqWeQ[0], reqLenQ[0]);
			errors++;
		end
		if (strobeCount - strobeStart != 8)
		begin
			$display("CHECK FAILED memWrStrobe count got %h expected %h", strobeCount - strobeStart, 8);
			errors++;
		end
		for (int i = 0; i < 8; i++)
		begin
			if (memWord(addrT'(22'h000100 + i)) !== dataT'(16'ha000 + i))
			begin
				$display("CHECK FAILED memWrData word %0d got %h expected %h", i,
					memWord(addrT'(22'h000100 + i)), dataT'(16'ha000 + i));
				errors++;
			end
		end
	endtask

	task automatic testReadBurst();
		int base;
		testsRun++;
		clearLog();
		base = burstsDone;
		for (int i = 0; i < 8; i++)
			memory[addrT'(22'h000300 + i)] = dataT'(16'hb000 + i);
		loadRead(1, 22'h000300, 22'h000400, 8);
		waitBurstCount(base + 1);
		@(negedge CLK);
		if (rdLevel[1] !== levelT'(8))
		begin
			$display("CHECK FAILED rdLevel[1] got %h expected %h", rdLevel[1], levelT'(8));
			errors++;
		end
		@(posedge CLK);
		#DRIVE_DELAY;
		ackHold = 1'b1;		// Refill request waits while the words drain
		rdPop[1] = 1'b1;
		for (int i = 0; i < 8; i++)
		begin
			@(negedge CLK);
			if (rdData[1] !== dataT'(16'hb000 + i))
			begin
				$display("CHECK FAILED rdData[1] got %h expected %h", rdData[1], dataT'(16'hb000 + i));
				errors++;
			end
			@(posedge CLK);
			#DRIVE_DELAY;
		end
		rdPop[1] = 1'b0;
		@(negedge CLK);
		if (rdEmpty[1] !== 1'b1)
		begin
			$display("CHECK FAILED rdEmpty[1] got %h expected 1", rdEmpty[1]);
			errors++;
		end
		@(posedge CLK);
		#DRIVE_DELAY;
		rdLoad[1] = 1'b1;		// Port goes idle, the pending refill still completes
		rdLength[1] = '0;
		ackHold = 1'b0;
		@(posedge CLK);
		#DRIVE_DELAY;
		rdLoad[1] = 1'b0;
		waitBurstCount(base + 2);
	endtask

	task automatic testAddrWrap();
		int base;
		addrT expAddr [3];
		testsRun++;
		expAddr = '{22'h000400, 22'h000408, 22'h000400};	// Two bursts fit, then wrap
		clearLog();
		base = burstsDone;
		loadWrite(1, 22'h000400, 22'h000410, 8);
		pushWords(1, 24, 16'hc000);
		waitBurstCount(base + 3);
		if (reqAddrQ.size() != 3)
		begin
			$display("Expected three memory requests for the wrap test, saw %0d", reqAddrQ.size());
			errors++;
		end
		else
		begin
			for (int i = 0; i < 3; i++)
			begin
				if (reqAddrQ[i] !== expAddr[i])
				begin
					$display("CHECK FAILED memAddr burst %0d got %h expected %h", i, reqAddrQ[i],
						expAddr[i]);
					errors++;
				end
			end
		end
	endtask

	task automatic testPriority();
		int base;
		testsRun++;
		clearLog();
		base = burstsDone;
		loadWrite(0, 22'h000500, 22'h000600, 4);
		pushWords(0, 3, 16'hd000);
		wrData[0] = 16'hd003;		// Last word and read load on the same edge
		wrPush[0] = 1'b1;
		rdLoad[0] = 1'b1;
		rdStart[0] = 22'h000300;
		rdMax[0] = 22'h000400;
		rdLength[0] = 9'd4;
		@(posedge CLK);
		#DRIVE_DELAY;
		wrPush[0] = 1'b0;
		rdLoad[0] = 1'b0;
		waitBurstCount(base + 2);
		if (reqWeQ.size() != 2)
		begin
			$display("Expected two memory requests for the priority test, saw %0d", reqWeQ.size());
			errors++;
		end
		else if (reqWeQ[0] !== 1'b0 || reqAddrQ[0] !== 22'h000300 || reqWeQ[1] !== 1'b1)
		begin
			$display("CHECK FAILED memWe first/second got %h/%h expected 0/1, memAddr %h expected %h",
				reqWeQ[0], reqWeQ[1], reqAddrQ[0], 22'h000300);
			errors++;
		end
		loadRead(0, '0, '0, '0);
	endtask

	task automatic testFifoFlags();
		testsRun++;
		loadWrite(1, '0, '0, '0);	// Length zero keeps the port from requesting
		pushWords(1, FIFO_DEPTH, 16'he000);
		@(negedge CLK);
		if (wrFull[1] !== 1'b1 || wrLevel[1] !== levelT'(FIFO_DEPTH))
		begin
			$display("CHECK FAILED wrFull/wrLevel[1] got %h/%h expected 1/%h", wrFull[1], wrLevel[1],
				levelT'(FIFO_DEPTH));
			errors++;
		end
		@(posedge CLK);
		#DRIVE_DELAY;
		pushWords(1, 1, 16'hffff);
		@(negedge CLK);
		if (wrLevel[1] !== levelT'(FIFO_DEPTH))
		begin
			$display("CHECK FAILED wrLevel[1] got %h expected %h", wrLevel[1], levelT'(FIFO_DEPTH));
			errors++;
		end
		@(posedge CLK);
		#DRIVE_DELAY;
		loadWrite(1, '0, '0, '0);
		@(negedge CLK);
		if (wrLevel[1] !== '0 || wrFull[1] !== 1'b0)
		begin
			$display("CHECK FAILED wrLevel/wrFull[1] got %h/%h expected 0/0", wrLevel[1], wrFull[1]);
			errors++;
		end
	endtask

	initial
	begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("Tests run: %0d, errors: %0d", testsRun, errors);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin : mainSeq
		RESET_N = 1'b0;
		wrPush = '0;
		wrLoad = '0;
		rdPop = '0;
		rdLoad = '0;
		memAck = 1'b0;
		memRdValid = 1'b0;
		memRdData = '0;
		for (int i = 0; i < WR_PORTS; i++)
		begin
			wrData[i] = '0;
			wrStart[i] = '0;
			wrMax[i] = '0;
			wrLength[i] = '0;
		end
		for (int i = 0; i < RD_PORTS; i++)
		begin
			rdStart[i] = '0;
			rdMax[i] = '0;
			rdLength[i] = '0;
		end
		repeat (3) @(posedge CLK);
		#DRIVE_DELAY RESET_N = 1'b1;
		testReset();
		testWriteBurst();
		testReadBurst();
		testAddrWrap();
		testPriority();
		testFifoFlags();
		$display("Tests run: %0d, errors: %0d", testsRun, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* src.f */
frameBufPkg.sv
portFifo.sv
writePort.sv
readPort.sv
burstArbiter.sv
burstSequencer.sv
frameBufCtrl.sv
frameBufCtrlTb.sv
